/* flist.f */
logic/ooo_isa_pkg.sv
logic/ooo_core_pkg.sv
logic/dispatch_rename.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/ooo_core.sv
dv/ooo_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = ooo_tb
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/ooo_tb.sv */
`timescale 1ns/1ns

module ooo_tb;
    import ooo_isa_pkg::*;
    import ooo_core_pkg::*;

    localparam int chain_len = 8;
    localparam int mixed_len = 12;
    localparam int pressure_len = 13;
    localparam int waw_len = 8;
    localparam int random_len = 300;
    localparam int total_instrs = chain_len + mixed_len + pressure_len + waw_len + random_len;
    localparam int watchdog_cycles = total_instrs * 200 + 2000;

    logic clk;
    logic reset;
    dispatch_t dispatch_in;
    logic stall;
    logic idle;
    cdb_t cdb;
    reg_idx_t read_addr;
    data_t read_data;

    // program-order model of the register file
    data_t ref_regs [num_regs];
    logic [num_tags-1:0] tags_live;
    // expected broadcast value per live tag
    data_t tag_value [num_tags];
    data_t accept_value;
    logic [15:0] lfsr_state;
    logic stall_seen;
    int checks_done;

    ooo_core dut_i (
        .clk(clk), .reset(reset), .dispatch_in(dispatch_in), .stall(stall), .idle(idle),
        .cdb(cdb), .read_addr(read_addr), .read_data(read_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("TB FAILED");
        $display("%s", line);
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t expected);
        checks_done++;
        if (got !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s got %h expected %h",
                $time, name, got, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        checks_done++;
        if (got !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s got %b expected %b",
                $time, name, got, expected));
        end
    endtask

    task automatic check_cdb_tag(input tag_t tag);
        checks_done++;
        if (tag == '0) begin
            stop_run($sformatf("CDB broadcast at %0t carries tag 0", $time));
        end else if (!tags_live[tag]) begin
            stop_run($sformatf("tag %0d on the CDB at %0t was never allocated", tag, $time));
        end
    endtask

    // 16-bit fibonacci, taps 16 14 13 11
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    task automatic apply_ref(input dispatch_t d, output data_t v);
        data_t a;
        data_t b;
        a = ref_regs[d.rs1];
        b = ref_regs[d.rs2];
        case (d.op)
            add:     v = a + b;
            sub:     v = a - b;
            and_op:  v = a & b;
            xor_op:  v = a ^ b;
            li:      v = {8'h00, d.imm};
            mul:     v = a * b;
            default: v = '0;
        endcase
        if (d.rd != '0) begin
            ref_regs[d.rd] = v;
        end
    endtask

    // lowest free tag goes to each accepted instruction
    task automatic claim_tag(input data_t value);
        int pick;
        pick = 0;
        for (int t = num_tags - 1; t >= 1; t--) begin
            if (!tags_live[t]) begin
                pick = t;
            end
        end
        if (pick == 0) begin
            stop_run("dispatch accepted an instruction while every tag was in use");
        end else begin
            tags_live[pick] = 1'b1;
            tag_value[pick] = value;
        end
    endtask

    // watch accepts and broadcasts mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            #2;
            if (!reset) begin
                if (cdb.valid) begin
                    check_cdb_tag(cdb.tag);
                    check_data("cdb.value", cdb.value, tag_value[cdb.tag]);
                end
                if (dispatch_in.valid && !stall) begin
                    apply_ref(dispatch_in, accept_value);
                    claim_tag(accept_value);
                end
                if (cdb.valid) begin
                    tags_live[cdb.tag] = 1'b0;
                end
            end
        end
    end

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic send_instr(input op_e code, input reg_idx_t dst, input reg_idx_t src1,
                              input reg_idx_t src2, input logic [7:0] imm);
        dispatch_in = '{valid: 1'b1, op: code, rd: dst, rs1: src1, rs2: src2, imm: imm};
        #1;
        while (stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    endtask

    task automatic wait_idle();
        dispatch_in.valid = 1'b0;
        while (!idle) begin
            @(negedge clk);
        end
        check_bit("tags outstanding", |tags_live, 1'b0);
    endtask

    task automatic check_regs();
        for (int r = 0; r < num_regs; r++) begin
            @(negedge clk);
            read_addr = reg_idx_t'(r);
            #1;
            check_data($sformatf("r%0d", r), read_data, ref_regs[r]);
        end
        @(negedge clk);
    endtask

    task automatic test_reset();
        check_bit("idle", idle, 1'b1);
        check_bit("stall", stall, 1'b0);
        check_bit("cdb.valid", cdb.valid, 1'b0);
        check_regs();
    endtask

    task automatic test_alu_chain();
        send_instr(li, 3'd1, 3'd0, 3'd0, 8'h12);
        send_instr(li, 3'd2, 3'd0, 3'd0, 8'h34);
        send_instr(add, 3'd3, 3'd1, 3'd2, 8'h00);
        send_instr(sub, 3'd4, 3'd3, 3'd1, 8'h00);
        send_instr(and_op, 3'd5, 3'd4, 3'd3, 8'h00);
        send_instr(xor_op, 3'd6, 3'd5, 3'd4, 8'h00);
        send_instr(add, 3'd7, 3'd6, 3'd6, 8'h00);
        send_instr(sub, 3'd1, 3'd7, 3'd1, 8'h00);
        wait_idle();
        check_regs();
    endtask

    task automatic test_mixed();
        send_instr(li, 3'd1, 3'd0, 3'd0, 8'd3);
        send_instr(li, 3'd2, 3'd0, 3'd0, 8'd200);
        send_instr(mul, 3'd3, 3'd1, 3'd2, 8'h00);
        send_instr(add, 3'd4, 3'd1, 3'd2, 8'h00);
        send_instr(mul, 3'd5, 3'd3, 3'd2, 8'h00);
        send_instr(xor_op, 3'd6, 3'd4, 3'd1, 8'h00);
        send_instr(sub, 3'd7, 3'd5, 3'd4, 8'h00);
        send_instr(li, 3'd1, 3'd0, 3'd0, 8'hff);
        send_instr(mul, 3'd2, 3'd1, 3'd1, 8'h00);
        send_instr(and_op, 3'd4, 3'd7, 3'd2, 8'h00);
        send_instr(add, 3'd6, 3'd6, 3'd1, 8'h00);
        send_instr(mul, 3'd3, 3'd4, 3'd6, 8'h00);
        wait_idle();
        check_regs();
    endtask

    // dependent multiplies pile up in the two-entry station
    task automatic test_pressure();
        stall_seen = 1'b0;
        send_instr(li, 3'd1, 3'd0, 3'd0, 8'd3);
        send_instr(li, 3'd2, 3'd0, 3'd0, 8'd5);
        for (int i = 0; i < 5; i++) begin
            send_instr(mul, 3'd1, 3'd1, 3'd2, 8'h00);
            send_instr(mul, 3'd3, 3'd1, 3'd1, 8'h00);
        end
        wait_idle();
        check_bit("stall seen", stall_seen, 1'b1);
        // drained core takes a new multiply at once
        dispatch_in = '{valid: 1'b1, op: mul, rd: 3'd3, rs1: 3'd1, rs2: 3'd2, imm: 8'h00};
        #1;
        check_bit("stall", stall, 1'b0);
        @(negedge clk);
        wait_idle();
        check_regs();
    endtask

    task automatic test_waw();
        send_instr(li, 3'd3, 3'd0, 3'd0, 8'd5);
        send_instr(li, 3'd4, 3'd0, 3'd0, 8'd7);
        send_instr(mul, 3'd2, 3'd3, 3'd4, 8'h00);
        send_instr(add, 3'd2, 3'd3, 3'd4, 8'h00);
        send_instr(li, 3'd0, 3'd0, 3'd0, 8'h55);
        send_instr(xor_op, 3'd0, 3'd3, 3'd4, 8'h00);
        send_instr(mul, 3'd5, 3'd0, 3'd3, 8'h00);
        send_instr(sub, 3'd6, 3'd2, 3'd0, 8'h00);
        wait_idle();
        check_regs();
        read_addr = 3'd0;
        #1;
        check_data("r0", read_data, 16'h0000);
        @(negedge clk);
    endtask

    task automatic test_random();
        logic [15:0] bits;
        logic [2:0] code;
        reg_idx_t dst;
        reg_idx_t src1;
        reg_idx_t src2;
        for (int i = 0; i < random_len; i++) begin
            bits = rand_bits(3);
            code = bits[2:0];
            if (code > 3'd5) begin
                code = code - 3'd6;
            end
            bits = rand_bits(9);
            dst = bits[2:0];
            src1 = bits[5:3];
            src2 = bits[8:6];
            bits = rand_bits(8);
            send_instr(op_e'(code), dst, src1, src2, bits[7:0]);
        end
        wait_idle();
        check_regs();
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_run("watchdog expired, the run hung with instructions still in flight");
    end

    initial begin
        reset = 1'b1;
        dispatch_in = '0;
        read_addr = '0;
        tags_live = '0;
        lfsr_state = 16'd21686;
        stall_seen = 1'b0;
        checks_done = 0;
        for (int r = 0; r < num_regs; r++) begin
            ref_regs[r] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_reset();
        test_alu_chain();
        test_mixed();
        test_pressure();
        test_waw();
        test_random();
        if (checks_done > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_run("no checks ran");
        end
    end

endmodule

/* logic/ooo_core.sv */
`timescale 1ns/1ns

module ooo_core (
    input  logic                    clk,
    input  logic                    reset,
    input  ooo_core_pkg::dispatch_t dispatch_in,
    output logic                    stall,
    output logic                    idle,
    output ooo_core_pkg::cdb_t      cdb,
    input  ooo_isa_pkg::reg_idx_t   read_addr,
    output ooo_isa_pkg::data_t      read_data
);
    import ooo_core_pkg::*;

    rs_entry_t alu_entry;
    rs_entry_t mul_entry;
    logic alu_write;
    logic mul_write;
    logic alu_full;
    logic mul_full;
    issue_t alu_issue;
    issue_t mul_issue;
    logic alu_busy;
    logic mul_busy;
    cdb_t alu_result;
    cdb_t mul_result;
    logic alu_grant;
    logic mul_grant;

    dispatch_rename dispatch_i (
        .clk(clk), .reset(reset), .dispatch_in(dispatch_in), .cdb(cdb),
        .alu_full(alu_full), .mul_full(mul_full), .stall(stall), .idle(idle),
        .alu_entry(alu_entry), .alu_write(alu_write),
        .mul_entry(mul_entry), .mul_write(mul_write),
        .read_addr(read_addr), .read_data(read_data)
    );

    reservation_station #(.depth(alu_rs_depth)) alu_rs_i (
        .clk(clk), .reset(reset), .entry_in(alu_entry), .write(alu_write), .cdb(cdb),
        .unit_busy(alu_busy), .full(alu_full), .issue(alu_issue)
    );

    reservation_station #(.depth(mul_rs_depth)) mul_rs_i (
        .clk(clk), .reset(reset), .entry_in(mul_entry), .write(mul_write), .cdb(cdb),
        .unit_busy(mul_busy), .full(mul_full), .issue(mul_issue)
    );

    alu_unit alu_i (
        .clk(clk), .reset(reset), .issue(alu_issue), .grant(alu_grant),
        .busy(alu_busy), .result(alu_result)
    );

    mul_unit mul_i (
        .clk(clk), .reset(reset), .issue(mul_issue), .grant(mul_grant),
        .busy(mul_busy), .result(mul_result)
    );

    cdb_arbiter arbiter_i (
        .clk(clk), .reset(reset), .alu_result(alu_result), .mul_result(mul_result),
        .alu_grant(alu_grant), .mul_grant(mul_grant), .cdb(cdb)
    );

endmodule

/* logic/cdb_arbiter.sv */
`timescale 1ns/1ns

module cdb_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  ooo_core_pkg::cdb_t alu_result,
    input  ooo_core_pkg::cdb_t mul_result,
    output logic               alu_grant,
    output logic               mul_grant,
    output ooo_core_pkg::cdb_t cdb
);

    // set when the multiplier won the last contested or single grant
    logic mul_won_last;

    assign alu_grant = alu_result.valid && (!mul_result.valid || mul_won_last);
    assign mul_grant = mul_result.valid && (!alu_result.valid || !mul_won_last);

    always_comb begin
        cdb = '0;
        if (alu_grant) begin
            cdb = alu_result;
        end else if (mul_grant) begin
            cdb = mul_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_won_last <= 1'b0;
        end else if (alu_grant) begin
            mul_won_last <= 1'b0;
        end else if (mul_grant) begin
            mul_won_last <= 1'b1;
        end
    end

endmodule

/* logic/mul_unit.sv */
`timescale 1ns/1ns

module mul_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  ooo_core_pkg::issue_t issue,
    input  logic                 grant,
    output logic                 busy,
    output ooo_core_pkg::cdb_t   result
);
    import ooo_isa_pkg::*;
    import ooo_core_pkg::*;

    logic s1_valid;
    tag_t s1_tag;
    data_t s1_a;
    data_t s1_b;

    logic s2_valid;
    tag_t s2_tag;
    data_t s2_lo;
    logic [7:0] s2_hi;

    logic [15:0] prod_lo;
    logic [7:0] prod_hi;
    logic freeze;

    // split on b's bytes, the high half only needs its low 8 bits
    assign prod_lo = s1_a * s1_b[7:0];
    assign prod_hi = s1_a[7:0] * s1_b[15:8];

    // whole pipe stops while the last stage waits for the CDB
    assign freeze = result.valid && !grant;
    assign busy = freeze;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            result.valid <= 1'b0;
        end else if (!freeze) begin
            s1_valid <= issue.valid;
            s1_tag <= issue.rd_tag;
            s1_a <= issue.a;
            s1_b <= issue.b;

            s2_valid <= s1_valid;
            s2_tag <= s1_tag;
            s2_lo <= prod_lo;
            s2_hi <= prod_hi;

            result.valid <= s2_valid;
            result.tag <= s2_tag;
            result.value <= s2_lo + {s2_hi, 8'h00};
        end
    end

endmodule

/* logic/alu_unit.sv */
`timescale 1ns/1ns

module alu_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  ooo_core_pkg::issue_t issue,
    input  logic                 grant,
    output logic                 busy,
    output ooo_core_pkg::cdb_t   result
);
    import ooo_isa_pkg::*;

    data_t alu_value;

    always_comb begin
        case (issue.op)
            add:     alu_value = issue.a + issue.b;
            sub:     alu_value = issue.a - issue.b;
            and_op:  alu_value = issue.a & issue.b;
            xor_op:  alu_value = issue.a ^ issue.b;
            li:      alu_value = issue.a;
            default: alu_value = '0;
        endcase
    end

    // result held until the arbiter takes it
    assign busy = result.valid && !grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (!busy) begin
            result.valid <= issue.valid;
            result.tag <= issue.rd_tag;
            result.value <= alu_value;
        end
    end

endmodule

/* logic/reservation_station.sv */
`timescale 1ns/1ns

module reservation_station #(
    parameter int depth = ooo_core_pkg::alu_rs_depth
) (
    input  logic                    clk,
    input  logic                    reset,
    input  ooo_core_pkg::rs_entry_t entry_in,
    input  logic                    write,
    input  ooo_core_pkg::cdb_t      cdb,
    input  logic                    unit_busy,
    output logic                    full,
    output ooo_core_pkg::issue_t    issue
);
    import ooo_core_pkg::*;

    rs_entry_t [depth-1:0] slots;
    // one past the youngest birthday written here
    birthday_t next_birthday;

    logic [depth-1:0] rs1_ok;
    logic [depth-1:0] rs2_ok;
    logic [depth-1:0] ready;
    int free_idx;
    int sel_idx;
    logic found;
    birthday_t best_age;
    logic issue_fire;
    logic do_write;

    // operands already held or arriving on the CDB right now
    always_comb begin
        for (int i = 0; i < depth; i++) begin
            rs1_ok[i] = slots[i].rs1_ready || (cdb.valid && cdb.tag == slots[i].rs1_tag);
            rs2_ok[i] = slots[i].rs2_ready || (cdb.valid && cdb.tag == slots[i].rs2_tag);
            ready[i] = slots[i].valid && rs1_ok[i] && rs2_ok[i];
        end
    end

    always_comb begin
        free_idx = 0;
        full = 1'b1;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                free_idx = i;
                full = 1'b0;
            end
        end
    end

    assign do_write = write && !full;

    // oldest = largest distance back from next_birthday, safe across wrap
    always_comb begin
        birthday_t age;
        found = 1'b0;
        sel_idx = 0;
        best_age = '0;
        for (int i = 0; i < depth; i++) begin
            age = next_birthday - slots[i].birthday;
            if (ready[i] && (!found || age > best_age)) begin
                found = 1'b1;
                sel_idx = i;
                best_age = age;
            end
        end
    end

    assign issue_fire = found && !unit_busy;

    always_comb begin
        issue.valid = issue_fire;
        issue.op = slots[sel_idx].op;
        issue.rd_tag = slots[sel_idx].rd_tag;
        // forward from CDB when the operand is woken this cycle
        issue.a = slots[sel_idx].rs1_ready ? slots[sel_idx].rs1_value : cdb.value;
        issue.b = slots[sel_idx].rs2_ready ? slots[sel_idx].rs2_value : cdb.value;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            next_birthday <= '0;
        end else if (do_write) begin
            next_birthday <= entry_in.birthday + 1'b1;
        end

        for (int i = 0; i < depth; i++) begin
            if (reset) begin
                slots[i].valid <= 1'b0;
            end else if (do_write && i == free_idx) begin
                slots[i] <= entry_in;
            end else if (issue_fire && i == sel_idx) begin
                slots[i].valid <= 1'b0;
            end else if (slots[i].valid && cdb.valid) begin
                if (!slots[i].rs1_ready && slots[i].rs1_tag == cdb.tag) begin
                    slots[i].rs1_value <= cdb.value;
                    slots[i].rs1_ready <= 1'b1;
                end
                if (!slots[i].rs2_ready && slots[i].rs2_tag == cdb.tag) begin
                    slots[i].rs2_value <= cdb.value;
                    slots[i].rs2_ready <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/dispatch_rename.sv */
`timescale 1ns/1ns

module dispatch_rename (
    input  logic                      clk,
    input  logic                      reset,
    input  ooo_core_pkg::dispatch_t   dispatch_in,
    input  ooo_core_pkg::cdb_t        cdb,
    input  logic                      alu_full,
    input  logic                      mul_full,
    output logic                      stall,
    output logic                      idle,
    output ooo_core_pkg::rs_entry_t   alu_entry,
    output logic                      alu_write,
    output ooo_core_pkg::rs_entry_t   mul_entry,
    output logic                      mul_write,
    input  ooo_isa_pkg::reg_idx_t     read_addr,
    output ooo_isa_pkg::data_t        read_data
);
    import ooo_isa_pkg::*;
    import ooo_core_pkg::*;

    data_t regs [num_regs];
    tag_t reg_tag [num_regs];
    // bit 0 is never set
    logic [num_tags-1:0] tag_busy;
    birthday_t next_birthday;

    tag_t free_tag;
    logic tag_avail;
    logic to_mul;
    logic accept;
    reg_idx_t [1:0] src_idx;
    tag_t [1:0] src_tag;
    logic [1:0] src_ready;
    data_t [1:0] src_value;
    rs_entry_t entry;

    // lowest free tag wins
    always_comb begin
        free_tag = '0;
        tag_avail = 1'b0;
        for (int t = num_tags - 1; t >= 1; t--) begin
            if (!tag_busy[t]) begin
                free_tag = tag_t'(t);
                tag_avail = 1'b1;
            end
        end
    end

    assign to_mul = (dispatch_in.op == mul);
    assign stall = dispatch_in.valid && (!tag_avail || (to_mul ? mul_full : alu_full));
    assign accept = dispatch_in.valid && !stall;
    assign idle = ~|tag_busy;
    assign read_data = regs[read_addr];

    // rename lookup, with a same-cycle CDB hit counting as ready
    always_comb begin
        src_idx[0] = dispatch_in.rs1;
        src_idx[1] = dispatch_in.rs2;
        for (int s = 0; s < 2; s++) begin
            src_tag[s] = (src_idx[s] == '0) ? '0 : reg_tag[src_idx[s]];
            src_ready[s] = 1'b1;
            src_value[s] = regs[src_idx[s]];
            if (src_tag[s] != '0) begin
                if (cdb.valid && cdb.tag == src_tag[s]) begin
                    src_value[s] = cdb.value;
                end else begin
                    src_ready[s] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        entry.valid = 1'b1;
        entry.op = dispatch_in.op;
        entry.rs1_tag = src_tag[0];
        entry.rs2_tag = src_tag[1];
        entry.rs1_ready = src_ready[0];
        entry.rs2_ready = src_ready[1];
        entry.rs1_value = src_value[0];
        entry.rs2_value = src_value[1];
        entry.rd_tag = free_tag;
        entry.birthday = next_birthday;
        // immediate travels as operand a
        if (dispatch_in.op == li) begin
            entry.rs1_tag = '0;
            entry.rs2_tag = '0;
            entry.rs1_ready = 1'b1;
            entry.rs2_ready = 1'b1;
            entry.rs1_value = {8'h00, dispatch_in.imm};
            entry.rs2_value = '0;
        end
    end

    assign alu_entry = entry;
    assign mul_entry = entry;
    assign alu_write = accept && !to_mul;
    assign mul_write = accept && to_mul;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_busy <= '0;
            next_birthday <= '0;
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
                reg_tag[r] <= '0;
            end
        end else begin
            if (cdb.valid) begin
                tag_busy[cdb.tag] <= 1'b0;
                // only where the map still points at this producer
                for (int r = 1; r < num_regs; r++) begin
                    if (reg_tag[r] == cdb.tag) begin
                        regs[r] <= cdb.value;
                        reg_tag[r] <= '0;
                    end
                end
            end
            if (accept) begin
                tag_busy[free_tag] <= 1'b1;
                next_birthday <= next_birthday + 1'b1;
                if (dispatch_in.rd != '0) begin
                    reg_tag[dispatch_in.rd] <= free_tag;
                end
            end
        end
    end

endmodule

/* logic/ooo_core_pkg.sv */
package ooo_core_pkg;

    localparam int tag_width = 4;
    localparam int num_tags = 2 ** tag_width;
    localparam int birthday_width = 8;
    localparam int alu_rs_depth = 4;
    localparam int mul_rs_depth = 2;

    // tag 0 means the value sits in the register file
    typedef logic [tag_width-1:0] tag_t;
    typedef logic [birthday_width-1:0] birthday_t;

    typedef struct packed {
        logic                valid;
        ooo_isa_pkg::op_e      op;
        ooo_isa_pkg::reg_idx_t rd;
        ooo_isa_pkg::reg_idx_t rs1;
        ooo_isa_pkg::reg_idx_t rs2;
        logic [7:0]          imm;
    } dispatch_t;

    typedef struct packed {
        logic               valid;
        ooo_isa_pkg::op_e   op;
        tag_t               rs1_tag;
        tag_t               rs2_tag;
        logic               rs1_ready;
        logic               rs2_ready;
        ooo_isa_pkg::data_t rs1_value;
        ooo_isa_pkg::data_t rs2_value;
        tag_t               rd_tag;
        birthday_t          birthday;
    } rs_entry_t;

    typedef struct packed {
        logic               valid;
        ooo_isa_pkg::op_e   op;
        ooo_isa_pkg::data_t a;
        ooo_isa_pkg::data_t b;
        tag_t               rd_tag;
    } issue_t;

    typedef struct packed {
        logic               valid;
        tag_t               tag;
        ooo_isa_pkg::data_t value;
    } cdb_t;

endpackage

/* logic/ooo_isa_pkg.sv */
package ooo_isa_pkg;

    localparam int data_width = 16;
    localparam int num_regs = 8;

    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
    typedef logic [data_width-1:0] data_t;

    // li loads the 8-bit immediate, zero-extended
    // mul goes to the multiplier, all others to the ALU
    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        xor_op,
        li,
        mul
    } op_e;

endpackage
